//--- list.f
logic/fetch_pkg.sv
logic/fetch_pc_ctrl.sv
logic/fetch_ctrl.sv
logic/fetch_axil_reader.sv
logic/instr_queue.sv
logic/fetch_top.sv
tb/fetch_chk.sv
tb/fetch_tb.sv

//--- Makefile
TOP := fetch_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f list.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- tb/fetch_tb.sv
// instruction fetch testbench
// AXI-Lite memory model with random latency, scenario table and scoreboard
`timescale 1ns/100ps

module fetch_tb import fetch_pkg::*; ();

	localparam logic [31:0] SEED = 32'h7bab6e96;
	localparam addr_t MEM_KEY = 32'h5a3c_96e1;
	localparam int N_ROWS = 6;
	localparam int ROW_CYCLES = 2000;

	// instruction access, secure, unprivileged
	localparam logic [2:0] FETCH_PROT = 3'b100;

	typedef struct packed {
		logic		by_redirect;
		addr_t		start_pc;
		int			mid_after;
		addr_t		mid_pc;
		logic		long_stall;
		logic		rand_stall;
		logic [1:0]	lat_mask;
		addr_t		ecall_pc;
		int			n_expect;
	} row_t;

	logic clk;
	logic rst_n;
	logic go;
	logic redirect;
	addr_t redirect_pc;
	logic stall;
	instr_t retire_instr;
	addr_t pc_out;
	instr_t instr;
	logic instr_valid;
	addr_t araddr;
	logic arvalid;
	logic arready;
	logic [2:0] arprot;
	instr_t rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	row_t rows [N_ROWS];
	int errors;
	int checks;
	logic timed_out;
	logic [31:0] lat_rng;
	logic [31:0] stall_rng;
	logic [1:0] lat_mask;
	addr_t ecall_addr;
	addr_t next_go_pc;
	int ar_count;

	fetch_top fetch_top_i (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// memory contents as stored, little-endian
	function automatic instr_t mem_word(input addr_t a);
		return a ^ MEM_KEY;
	endfunction

	// word the core should see at this pc
	function automatic instr_t expected_word(input addr_t a);
		if (a == ecall_addr) begin
			return ECALL;
		end
		return swap_endian(mem_word(a));
	endfunction

	task automatic check_pc(input string name, input addr_t got, input addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_instr(input string name, input instr_t got, input instr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_state(input string name, input fetch_state_t got,
		input fetch_state_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s = %s, expected %s", $time, name, got.name(), exp.name());
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s = %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_prot(input string name, input logic [2:0] got,
		input logic [2:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s = %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic report_problem(input string what);
		errors++;
		$display("Error at %0t: %s", $time, what);
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#10;
	endtask

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	// AXI-Lite slave, each handshake delayed 0 to 3 cycles
	initial begin : memory_slave
		addr_t slave_addr;
		int ar_delay;
		int r_delay;
		logic r_pending;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		rresp = 2'b00;
		lat_rng = SEED;
		ar_count = 0;
		ar_delay = -1;
		r_delay = 0;
		r_pending = 1'b0;
		slave_addr = '0;
		forever begin
			next_cycle();
			if (!rst_n) begin
				arready = 1'b0;
				rvalid = 1'b0;
				r_pending = 1'b0;
				ar_delay = -1;
			end else begin
				// arready was up at the edge and arvalid never drops early
				if (arready) begin
					arready = 1'b0;
					slave_addr = araddr;
					check_prot("arprot", arprot, FETCH_PROT);
					ar_count++;
					lat_rng = xorshift(lat_rng);
					r_delay = int'(lat_rng[1:0] & lat_mask);
					r_pending = 1'b1;
					ar_delay = -1;
				end else if (arvalid) begin
					if (ar_delay < 0) begin
						lat_rng = xorshift(lat_rng);
						ar_delay = int'(lat_rng[1:0] & lat_mask);
					end
					if (ar_delay == 0) begin
						arready = 1'b1;
					end else begin
						ar_delay--;
					end
				end
				// rready is high in the data phase, so rvalid transfers at once
				if (rvalid) begin
					rvalid = 1'b0;
				end else if (r_pending) begin
					if (r_delay == 0) begin
						rvalid = 1'b1;
						rdata = (slave_addr == ecall_addr) ? swap_endian(ECALL) :
							mem_word(slave_addr);
						r_pending = 1'b0;
					end else begin
						r_delay--;
					end
				end
			end
		end
	end

	task automatic check_reset_state();
		repeat (3) begin
			@(negedge clk);
			check_flag("instr_valid", instr_valid, 1'b0);
			check_flag("arvalid", arvalid, 1'b0);
			check_flag("rready", rready, 1'b1);
			check_instr("instr", instr, NOP);
			check_pc("pc_out", pc_out, '0);
			check_pc("pc", fetch_top_i.pc, BOOT_PC);
			check_state("state", fetch_top_i.state, DEBUG);
		end
		next_cycle();
	endtask

	task automatic run_row(input row_t row);
		addr_t exp_pc;
		addr_t last_pc;
		instr_t last_instr;
		int got;
		int cycles;
		int ar_mark;
		logic mid_done;
		got = 0;
		cycles = 0;
		mid_done = 1'b0;
		last_pc = '0;
		last_instr = NOP;
		ecall_addr = row.ecall_pc;
		lat_mask = row.lat_mask;
		check_state("state", fetch_top_i.state, DEBUG);
		exp_pc = row.by_redirect ? row.start_pc : next_go_pc;
		if (row.by_redirect) begin
			redirect = 1'b1;
			redirect_pc = row.start_pc;
			next_cycle();
			redirect = 1'b0;
		end
		go = 1'b1;
		stall = row.long_stall;
		@(negedge clk);
		ar_mark = ar_count;
		next_cycle();
		go = 1'b0;
		if (row.long_stall) begin
			// queue fills up, then fetch has to sit in STALL
			repeat (100) next_cycle();
			@(negedge clk);
			if (ar_count - ar_mark > QUEUE_DEPTH + 1) begin
				report_problem("too many address transfers during a long stall");
			end
			check_state("state", fetch_top_i.state, STALL);
			next_cycle();
		end
		while (got < row.n_expect && cycles < ROW_CYCLES) begin
			stall_rng = xorshift(stall_rng);
			stall = row.rand_stall && (stall_rng[1:0] == 2'b00);
			redirect = 1'b0;
			if (got == row.mid_after && !mid_done) begin
				redirect = 1'b1;
				redirect_pc = row.mid_pc;
				exp_pc = row.mid_pc;
				mid_done = 1'b1;
			end
			@(negedge clk);
			if (instr_valid) begin
				check_pc("pc_out", pc_out, exp_pc);
				check_instr("instr", instr, expected_word(exp_pc));
				last_pc = pc_out;
				last_instr = instr;
				exp_pc = exp_pc + 4;
				got++;
			end
			cycles++;
			next_cycle();
		end
		stall = 1'b0;
		redirect = 1'b0;
		if (got < row.n_expect) begin
			report_problem("timed out waiting for the instructions of a row");
			timed_out = 1'b1;
			return;
		end
		// the ecall closes every row and nothing follows it
		check_pc("last pc_out", last_pc, row.ecall_pc);
		check_instr("last instr", last_instr, ECALL);
		@(negedge clk);
		ar_mark = ar_count;
		repeat (20) begin
			next_cycle();
			@(negedge clk);
			check_flag("instr_valid", instr_valid, 1'b0);
		end
		if (ar_count != ar_mark) begin
			report_problem("address transfer after the ecall was fetched");
		end
		next_cycle();
		check_state("state", fetch_top_i.state, ECALL_WAIT);
		retire_instr = ECALL;
		next_cycle();
		retire_instr = NOP;
		cycles = 0;
		while (fetch_top_i.state != DEBUG && cycles < 10) begin
			next_cycle();
			cycles++;
		end
		check_state("state", fetch_top_i.state, DEBUG);
		next_go_pc = row.ecall_pc + 4;
	endtask

	initial begin : stimulus
		int r;
		rst_n = 1'b0;
		go = 1'b0;
		redirect = 1'b0;
		redirect_pc = '0;
		stall = 1'b0;
		retire_instr = NOP;
		errors = 0;
		checks = 0;
		timed_out = 1'b0;
		stall_rng = SEED;
		lat_mask = 2'd3;
		ecall_addr = '0;
		next_go_pc = BOOT_PC;
		// redirect start, start pc, redirect after n, its target, long stall,
		// random stall, latency mask, ecall pc, instructions expected
		rows[0] = '{1'b0, BOOT_PC, -1, 32'h0, 1'b0, 1'b0, 2'd3, 32'h0000_1040, 17};
		rows[1] = '{1'b0, 32'h0, -1, 32'h0, 1'b0, 1'b1, 2'd3, 32'h0000_1080, 16};
		// redirect while in STALL, no read in flight
		rows[2] = '{1'b0, 32'h0, 0, 32'h0000_2000, 1'b1, 1'b1, 2'd3, 32'h0000_2030, 13};
		// redirect while FETCH has its read in flight
		rows[3] = '{1'b0, 32'h0, 3, 32'h0000_3000, 1'b0, 1'b0, 2'd3, 32'h0000_3020, 12};
		// same stream as row 0 with other latencies
		rows[4] = '{1'b1, BOOT_PC, -1, 32'h0, 1'b0, 1'b0, 2'd0, 32'h0000_1040, 17};
		rows[5] = '{1'b1, BOOT_PC, -1, 32'h0, 1'b0, 1'b1, 2'd3, 32'h0000_1040, 17};
		repeat (5) @(posedge clk);
		#10;
		rst_n = 1'b1;
		check_reset_state();
		for (r = 0; r < N_ROWS && !timed_out; r++) begin
			run_row(rows[r]);
		end
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			fetch_top_i.fetch_chk_i.fails);
		if (errors == 0 && fetch_top_i.fetch_chk_i.fails == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule : fetch_tb

//--- tb/fetch_chk.sv
// AXI-Lite and decode side protocol checker
// bound into the fetch top level
`timescale 1ns/100ps

module fetch_chk import fetch_pkg::*; (
	input	logic		clk,
	input	logic		rst_n,
	input	addr_t		araddr,
	input	logic		arvalid,
	input	logic		arready,
	input	logic		stall,
	input	logic		redirect,
	input	instr_t		instr,
	input	logic		instr_valid
);

	int fails = 0;

	// request held with its address until accepted
	ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else begin
			$error("arvalid or araddr changed while waiting for arready");
			fails++;
		end

	idle_nop: assert property (@(posedge clk) disable iff (!rst_n)
		!instr_valid |-> instr == NOP)
		else begin
			$error("instr is not NOP while nothing is offered");
			fails++;
		end

	no_offer: assert property (@(posedge clk) disable iff (!rst_n)
		(stall || redirect) |-> !instr_valid)
		else begin
			$error("instruction offered during stall or redirect");
			fails++;
		end

endmodule : fetch_chk

bind fetch_top fetch_chk fetch_chk_i (
	.clk			(clk),
	.rst_n			(rst_n),
	.araddr			(araddr),
	.arvalid		(arvalid),
	.arready		(arready),
	.stall			(stall),
	.redirect		(redirect),
	.instr			(instr),
	.instr_valid	(instr_valid)
);

//--- logic/fetch_top.sv
// instruction fetch top level
// FSM, pc, AXI-Lite reader and queue, output toward decode
`timescale 1ns/100ps

module fetch_top import fetch_pkg::*; (
	input	logic			clk,
	input	logic			rst_n,

	// decode and writeback side
	input	logic			go,
	input	logic			redirect,
	input	addr_t			redirect_pc,
	input	logic			stall,
	input	instr_t			retire_instr,
	output	addr_t			pc_out,
	output	instr_t			instr,
	output	logic			instr_valid,

	// AXI-Lite read channel
	output	addr_t			araddr,
	output	logic			arvalid,
	input	logic			arready,
	output	logic [2:0]		arprot,
	input	instr_t			rdata,
	input	logic [1:0]		rresp,
	input	logic			rvalid,
	output	logic			rready
);

	fetch_state_t state;
	addr_t pc;
	addr_t q_pc;
	instr_t q_instr;
	instr_t read_data;
	logic read_req;
	logic read_busy;
	logic read_done;
	logic drop_resp;
	logic redirect_pending;
	logic q_wr;
	logic q_empty;
	logic q_almost_full;

	// cancelled responses never reach the queue
	assign q_wr = read_done && !drop_resp;

	// consumed in every cycle it is offered
	assign instr_valid = !q_empty && !stall && !redirect && !redirect_pending;
	assign instr = instr_valid ? swap_endian(q_instr) : NOP;
	assign pc_out = instr_valid ? q_pc : '0;

	fetch_ctrl fetch_ctrl_i (
		.clk			(clk),
		.rst_n			(rst_n),
		.go				(go),
		.read_done		(read_done),
		.read_data		(read_data),
		.almost_full	(q_almost_full),
		.retire_instr	(retire_instr),
		.drop_resp		(drop_resp),
		.read_req		(read_req),
		.read_busy		(read_busy),
		.state			(state)
	);

	fetch_pc_ctrl fetch_pc_ctrl_i (
		.clk				(clk),
		.rst_n				(rst_n),
		.read_done			(read_done),
		.read_busy			(read_busy),
		.redirect			(redirect),
		.redirect_pc		(redirect_pc),
		.pc					(pc),
		.drop_resp			(drop_resp),
		.redirect_pending	(redirect_pending)
	);

	fetch_axil_reader fetch_axil_reader_i (
		.clk		(clk),
		.rst_n		(rst_n),
		.read_req	(read_req),
		.addr		(pc),
		.araddr		(araddr),
		.arvalid	(arvalid),
		.arready	(arready),
		.arprot		(arprot),
		.rdata		(rdata),
		.rresp		(rresp),
		.rvalid		(rvalid),
		.rready		(rready),
		.read_done	(read_done),
		.read_data	(read_data)
	);

	// pc still holds the address of the read that just returned
	instr_queue instr_queue_i (
		.clk			(clk),
		.rst_n			(rst_n),
		.flush			(redirect),
		.wr_en			(q_wr),
		.wr_pc			(pc),
		.wr_instr		(read_data),
		.rd_en			(instr_valid),
		.rd_pc			(q_pc),
		.rd_instr		(q_instr),
		.empty			(q_empty),
		.almost_full	(q_almost_full),
		.count			()
	);

endmodule : fetch_top

//--- logic/instr_queue.sv
// instruction queue
// circular buffer of pc and instruction pairs with flush and almost-full
`timescale 1ns/100ps

module instr_queue import fetch_pkg::*; (
	input	logic			clk,
	input	logic			rst_n,

	input	logic			flush,
	input	logic			wr_en,
	input	addr_t			wr_pc,
	input	instr_t			wr_instr,
	input	logic			rd_en,

	output	addr_t			rd_pc,
	output	instr_t			rd_instr,
	output	logic			empty,
	output	logic			almost_full,
	output	queue_cnt_t		count
);

	addr_t pc_mem [QUEUE_DEPTH];
	instr_t instr_mem [QUEUE_DEPTH];

	// extra msb tells full from empty
	logic [QUEUE_DEPTH_LOG2:0] wr_ptr;
	logic [QUEUE_DEPTH_LOG2:0] rd_ptr;
	logic full;
	logic wr_fire;
	logic rd_fire;

	assign count = wr_ptr - rd_ptr;
	assign empty = (count == '0);
	assign full = count[QUEUE_DEPTH_LOG2];
	assign almost_full = (count >= queue_cnt_t'(QUEUE_ALMOST_FULL));

	assign wr_fire = wr_en && !full;
	assign rd_fire = rd_en && !empty;

	// flush beats a write in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_fire) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_fire) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_fire && !flush) begin
			pc_mem[wr_ptr[QUEUE_DEPTH_LOG2-1:0]] <= wr_pc;
			instr_mem[wr_ptr[QUEUE_DEPTH_LOG2-1:0]] <= wr_instr;
		end
	end

	// head entry shown without delay
	assign rd_pc = pc_mem[rd_ptr[QUEUE_DEPTH_LOG2-1:0]];
	assign rd_instr = instr_mem[rd_ptr[QUEUE_DEPTH_LOG2-1:0]];

endmodule : instr_queue

//--- logic/fetch_axil_reader.sv
// AXI-Lite read master for instruction fetch
// one AR/R transaction per request strobe, done strobe at the R transfer
`timescale 1ns/100ps

module fetch_axil_reader import fetch_pkg::*; (
	input	logic			clk,
	input	logic			rst_n,

	input	logic			read_req,
	input	addr_t			addr,

	// AXI-Lite read address channel
	output	addr_t			araddr,
	output	logic			arvalid,
	input	logic			arready,
	output	logic [2:0]		arprot,

	// AXI-Lite read data channel
	input	instr_t			rdata,
	input	logic [1:0]		rresp,
	input	logic			rvalid,
	output	logic			rready,

	output	logic			read_done,
	output	instr_t			read_data
);

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_DATA
	} rd_phase_t;

	rd_phase_t phase;
	rd_phase_t phase_nxt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= RD_IDLE;
		end else begin
			phase <= phase_nxt;
		end
	end

	always_comb begin
		phase_nxt = phase;
		unique case (phase)
			RD_IDLE: begin
				if (read_req) begin
					phase_nxt = RD_ADDR;
				end
			end
			RD_ADDR: begin
				if (arready) begin
					phase_nxt = RD_DATA;
				end
			end
			RD_DATA: begin
				if (rvalid) begin
					phase_nxt = RD_IDLE;
				end
			end
			default: begin
				phase_nxt = RD_IDLE;
			end
		endcase
	end

	// address held stable through the address phase
	always_ff @(posedge clk) begin
		if (phase == RD_IDLE && read_req) begin
			araddr <= addr;
		end
	end

	assign arvalid = (phase == RD_ADDR);

	// unprivileged, secure, instruction access
	assign arprot = 3'b100;

	// high at reset and all through the data phase
	assign rready = (phase != RD_ADDR);

	assign read_done = (phase == RD_DATA) && rvalid;
	assign read_data = rdata;

endmodule : fetch_axil_reader

//--- logic/fetch_ctrl.sv
// fetch control FSM
// issues one read at a time, pauses on a full queue, parks on ecall
`timescale 1ns/100ps

module fetch_ctrl import fetch_pkg::*; (
	input	logic			clk,
	input	logic			rst_n,

	input	logic			go,
	input	logic			read_done,
	input	instr_t			read_data,
	input	logic			almost_full,
	input	instr_t			retire_instr,
	input	logic			drop_resp,

	output	logic			read_req,
	output	logic			read_busy,
	output	fetch_state_t	state
);

	fetch_state_t state_nxt;
	logic busy_q;
	logic fetched_ecall;
	logic ecall_retired;

	// memory word arrives little-endian
	assign fetched_ecall = read_done && !drop_resp && (swap_endian(read_data) == ECALL);
	assign ecall_retired = (retire_instr == ECALL);

	// next request follows the cycle after read_done
	assign read_req = (state == FETCH) && !busy_q;
	assign read_busy = busy_q || read_req;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
		end else if (read_req) begin
			busy_q <= 1'b1;
		end else if (read_done) begin
			busy_q <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= DEBUG;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		unique case (state)
			DEBUG: begin
				if (go) begin
					state_nxt = FETCH;
				end
			end
			FETCH: begin
				// ecall wins over back-pressure, it must not be refetched
				if (fetched_ecall) begin
					state_nxt = ECALL_WAIT;
				end else if (read_done && almost_full) begin
					state_nxt = STALL;
				end
			end
			STALL: begin
				if (!almost_full) begin
					state_nxt = FETCH;
				end
			end
			ECALL_WAIT: begin
				// writeback reports the ecall as retired
				if (ecall_retired) begin
					state_nxt = DEBUG;
				end
			end
			default: begin
				state_nxt = DEBUG;
			end
		endcase
	end

endmodule : fetch_ctrl

//--- logic/fetch_pc_ctrl.sv
// fetch program counter
// boot value, advance by four per response, redirect target held over a busy read
`timescale 1ns/100ps

module fetch_pc_ctrl import fetch_pkg::*; (
	input	logic		clk,
	input	logic		rst_n,

	input	logic		read_done,
	input	logic		read_busy,
	input	logic		redirect,
	input	addr_t		redirect_pc,

	output	addr_t		pc,
	output	logic		drop_resp,
	output	logic		redirect_pending
);

	addr_t pc_plus4;
	addr_t held_pc;
	logic held_valid;
	logic load_now;
	logic load_held;

	assign pc_plus4 = pc + addr_t'(4);

	// target lands at once when the bus is idle or its read ends this cycle
	assign load_now = redirect && (!read_busy || read_done);

	// a stored target waits for the cancelled read to come back
	assign load_held = read_done && held_valid && !redirect;

	// response of a cancelled fetch
	assign drop_resp = read_done && (held_valid || redirect);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= BOOT_PC;
		end else if (load_now) begin
			pc <= redirect_pc;
		end else if (load_held) begin
			pc <= held_pc;
		end else if (read_done) begin
			pc <= pc_plus4;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			held_valid <= 1'b0;
		end else if (load_now) begin
			held_valid <= 1'b0;
		end else if (redirect) begin
			held_valid <= 1'b1;
		end else if (read_done) begin
			held_valid <= 1'b0;
		end
	end

	// latest target wins if several arrive during one read
	always_ff @(posedge clk) begin
		if (redirect && !load_now) begin
			held_pc <= redirect_pc;
		end
	end

	// output side stays quiet until the target stream reaches the queue
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			redirect_pending <= 1'b0;
		end else if (redirect) begin
			redirect_pending <= 1'b1;
		end else if (read_done && !drop_resp) begin
			redirect_pending <= 1'b0;
		end
	end

endmodule : fetch_pc_ctrl

//--- logic/fetch_pkg.sv
// fetch subsystem shared definitions
// data widths, queue sizing, instruction encodings and fetch states
package fetch_pkg;

	localparam int XLEN = 32;

	// eight entry instruction queue
	localparam int QUEUE_DEPTH_LOG2 = 3;
	localparam int QUEUE_DEPTH = 1 << QUEUE_DEPTH_LOG2;

	// fill level where fetch backs off
	// two slots stay free for a read already in flight
	localparam int QUEUE_ALMOST_FULL = QUEUE_DEPTH - 2;

	typedef logic [XLEN-1:0] addr_t;
	typedef logic [XLEN-1:0] instr_t;
	typedef logic [QUEUE_DEPTH_LOG2:0] queue_cnt_t;

	// reset value of the program counter
	localparam addr_t BOOT_PC = 32'h0000_1000;

	// environment call
	localparam instr_t ECALL = 32'h0000_0073;

	// addi x0, x0, 0
	localparam instr_t NOP = 32'h0000_0013;

	typedef enum logic [1:0] {
		DEBUG,
		FETCH,
		STALL,
		ECALL_WAIT
	} fetch_state_t;

	// memory is little-endian, the core big-endian
	function automatic instr_t swap_endian(input instr_t word);
		instr_t swapped;
		swapped = {word[7:0], word[15:8], word[23:16], word[31:24]};
		return swapped;
	endfunction

endpackage : fetch_pkg
